// File: frame_pkg.sv
package frame_pkg;

    ////////////////////
    // Protocol constants

    localparam logic [15:0] ethertype_ipv4  = 16'h0800;
    localparam logic [7:0]  ip_protocol_udp = 8'd17;

    // Ethernet 14 + IPv4 20 + UDP 8
    localparam int header_bytes     = 42;
    localparam int udp_header_bytes = 8;
    localparam int min_frame_bytes  = 60;
    localparam int fcs_bytes        = 4;

    ////////////////////
    // Header layout, first wire byte in the top bits

    typedef struct packed {
        logic [47:0] mac_destination;
        logic [47:0] mac_source;
        logic [15:0] ether_type;
        logic [7:0]  ipv4_version_ihl;
        logic [7:0]  ipv4_services;
        logic [15:0] ipv4_total_length;
        logic [15:0] ipv4_identification;
        // MF flag in bit 13, offset in 12:0
        logic [15:0] ipv4_flags_offset;
        logic [7:0]  ipv4_time_to_live;
        logic [7:0]  ipv4_protocol;
        logic [15:0] ipv4_header_checksum;
        logic [31:0] ipv4_source_address;
        logic [31:0] ipv4_destination_address;
        logic [15:0] udp_source_port;
        logic [15:0] udp_destination_port;
        logic [15:0] udp_length;
        logic [15:0] udp_checksum;
    } header_fields_t;

    // Filled byte by byte, read as fields
    typedef union packed {
        header_fields_t                 fields;
        logic [0:header_bytes-1][7:0]   bytes;
    } header_word_u;

endpackage

// File: rx_pkg.sv
package rx_pkg;

    ////////////////////
    // Input stream

    // One byte per valid cycle, start marks the first byte of a frame
    typedef struct packed {
        logic       valid;
        logic       start;
        logic [7:0] data;
    } rx_byte_t;

    ////////////////////
    // Sequencer

    typedef enum logic [2:0] {
        seq_idle,
        seq_header,
        seq_payload,
        seq_pad,
        seq_fcs,
        seq_check,
        seq_drop
    } seq_state_e;

    // Single cycle pulses for the current frame
    typedef struct packed {
        logic good;
        logic bad;
    } verdict_t;

    ////////////////////
    // CRC

    localparam int crc_residue_bits = 32;

endpackage

// File: header_capture.sv
`timescale 1ns/10ps
module header_capture (
    input  logic                    clock,
    input  logic                    reset_n,
    input  rx_pkg::rx_byte_t        rx_byte,
    input  logic                    capture,
    input  logic                    restart,
    output frame_pkg::header_word_u header,
    output logic                    header_done
);

    localparam int count_bits = $clog2(frame_pkg::header_bytes + 1);

    frame_pkg::header_word_u fill;
    frame_pkg::header_word_u fill_next;
    logic [count_bits-1:0]   count;
    logic [count_bits-1:0]   offset;
    logic                    last_byte;

    // First byte of a frame lands at offset zero
    assign offset    = restart ? '0 : count;
    assign last_byte = capture && (offset == count_bits'(frame_pkg::header_bytes - 1));

    always_comb begin
        fill_next = fill;
        if (capture) begin
            fill_next.bytes[offset] = rx_byte.data;
        end
    end

    always_ff @(posedge clock) begin
        fill <= fill_next;
    end

    // Published copy stays stable until the next header completes
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count       <= '0;
            header      <= '0;
            header_done <= 1'b0;
        end else begin
            if (restart) begin
                count <= count_bits'(capture);
            end else if (capture) begin
                count <= count + 1'b1;
            end
            if (last_byte) begin
                header <= fill_next;
            end
            header_done <= last_byte;
        end
    end

    // No more than one header's worth of bytes per frame
    assert property (@(posedge clock) disable iff (!reset_n)
        (capture && !restart) |-> (count < count_bits'(frame_pkg::header_bytes)));

endmodule

// File: frame_check.sv
`timescale 1ns/10ps
module frame_check (
    input  logic             clock,
    input  logic             reset_n,
    input  rx_pkg::rx_byte_t rx_byte,
    input  logic             crc_restart,
    input  logic             crc_byte,
    input  logic             fcs_byte,
    output logic             fcs_match
);

    localparam logic [rx_pkg::crc_residue_bits-1:0] crc_polynomial = 32'hEDB8_8320;

    logic [rx_pkg::crc_residue_bits-1:0] crc;
    logic [rx_pkg::crc_residue_bits-1:0] crc_seed;
    logic [rx_pkg::crc_residue_bits-1:0] crc_final;
    logic [rx_pkg::crc_residue_bits-1:0] fcs_received;
    logic                                fcs_active;

    // Reflected CRC-32, one byte, lsb first
    function automatic logic [rx_pkg::crc_residue_bits-1:0] crc_update(
        input logic [rx_pkg::crc_residue_bits-1:0] value,
        input logic [7:0]                          data
    );
        logic [rx_pkg::crc_residue_bits-1:0] c;
        c = value ^ {{(rx_pkg::crc_residue_bits - 8){1'b0}}, data};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc_polynomial;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_seed = crc_restart ? '1 : crc;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            crc        <= '1;
            fcs_active <= 1'b0;
        end else begin
            if (crc_byte) begin
                crc <= crc_update(crc_seed, rx_byte.data);
            end else if (crc_restart) begin
                crc <= '1;
            end
            if (crc_restart) begin
                fcs_active <= 1'b0;
            end else if (fcs_byte) begin
                fcs_active <= 1'b1;
            end
        end
    end

    // Received FCS arrives lsb first
    always_ff @(posedge clock) begin
        if (fcs_byte && !fcs_active) begin
            crc_final <= crc;
        end
        if (fcs_byte) begin
            fcs_received <= {rx_byte.data, fcs_received[rx_pkg::crc_residue_bits-1:8]};
        end
    end

    assign fcs_match = ((~crc_final) == fcs_received);

endmodule

// File: frame_sequencer.sv
`timescale 1ns/10ps
module frame_sequencer (
    input  logic                    clock,
    input  logic                    reset_n,
    input  rx_pkg::rx_byte_t        rx_byte,
    input  frame_pkg::header_word_u header,
    input  logic                    header_done,
    input  logic                    fcs_match,
    input  logic                    any_slot,
    output logic                    capture,
    output logic                    crc_restart,
    output logic                    crc_byte,
    output logic                    fcs_byte,
    output logic                    frame_start,
    output logic                    payload_byte,
    output rx_pkg::verdict_t        verdict
);

    localparam int pad_span = frame_pkg::min_frame_bytes - frame_pkg::header_bytes;
    localparam logic [1:0] fcs_last = 2'(frame_pkg::fcs_bytes - 1);

    rx_pkg::seq_state_e state;
    rx_pkg::seq_state_e phase;
    rx_pkg::seq_state_e state_next;
    logic [15:0]        payload_left;
    logic [15:0]        payload_phase;
    logic [15:0]        payload_next;
    logic [15:0]        payload_len;
    logic [7:0]         pad_left;
    logic [7:0]         pad_phase;
    logic [7:0]         pad_next;
    logic [7:0]         pad_len;
    logic [1:0]         fcs_left;
    logic [1:0]         fcs_next;
    logic               header_ok;
    logic               start_byte;

    ////////////////////
    // Header filter and lengths
    assign header_ok = (header.fields.ether_type == frame_pkg::ethertype_ipv4)
                    && (header.fields.ipv4_protocol == frame_pkg::ip_protocol_udp)
                    && (header.fields.ipv4_flags_offset[13:0] == 14'd0)
                    && (header.fields.udp_length >= 16'(frame_pkg::udp_header_bytes));

    assign payload_len = header.fields.udp_length - 16'(frame_pkg::udp_header_bytes);
    assign pad_len     = (payload_len < 16'(pad_span)) ? 8'(16'(pad_span) - payload_len) : '0;

    // The byte next to header_done already belongs to the new section
    always_comb begin
        phase         = state;
        payload_phase = payload_left;
        pad_phase     = pad_left;
        if (state == rx_pkg::seq_header && header_done) begin
            payload_phase = payload_len;
            pad_phase     = pad_len;
            if (!header_ok) begin
                phase = rx_pkg::seq_drop;
            end else if (payload_len != 16'd0) begin
                phase = rx_pkg::seq_payload;
            end else begin
                phase = rx_pkg::seq_pad;
            end
        end
    end

    assign start_byte = rx_byte.valid && rx_byte.start;

    ////////////////////
    // Byte dispatch
    always_comb begin
        state_next   = phase;
        payload_next = payload_phase;
        pad_next     = pad_phase;
        fcs_next     = fcs_left;
        capture      = 1'b0;
        crc_restart  = 1'b0;
        crc_byte     = 1'b0;
        fcs_byte     = 1'b0;
        frame_start  = 1'b0;
        payload_byte = 1'b0;
        verdict      = '0;
        if (phase == rx_pkg::seq_check) begin
            verdict.good = fcs_match;
            verdict.bad  = !fcs_match;
            state_next   = rx_pkg::seq_idle;
        end
        if (start_byte) begin
            // Abort of a frame in progress
            if (phase inside {rx_pkg::seq_header, rx_pkg::seq_payload,
                              rx_pkg::seq_pad, rx_pkg::seq_fcs}) begin
                verdict.bad = 1'b1;
            end
            if (any_slot) begin
                state_next  = rx_pkg::seq_header;
                capture     = 1'b1;
                crc_restart = 1'b1;
                crc_byte    = 1'b1;
                frame_start = 1'b1;
            end else begin
                state_next = rx_pkg::seq_drop;
            end
        end else if (rx_byte.valid) begin
            case (phase)
                rx_pkg::seq_header: begin
                    capture  = 1'b1;
                    crc_byte = 1'b1;
                end
                rx_pkg::seq_payload: begin
                    payload_byte = 1'b1;
                    crc_byte     = 1'b1;
                    payload_next = payload_phase - 1'b1;
                    if (payload_phase == 16'd1) begin
                        if (pad_phase != 8'd0) begin
                            state_next = rx_pkg::seq_pad;
                        end else begin
                            state_next = rx_pkg::seq_fcs;
                            fcs_next   = fcs_last;
                        end
                    end
                end
                rx_pkg::seq_pad: begin
                    crc_byte = 1'b1;
                    pad_next = pad_phase - 1'b1;
                    if (pad_phase == 8'd1) begin
                        state_next = rx_pkg::seq_fcs;
                        fcs_next   = fcs_last;
                    end
                end
                rx_pkg::seq_fcs: begin
                    fcs_byte = 1'b1;
                    fcs_next = fcs_left - 1'b1;
                    if (fcs_left == 2'd0) begin
                        state_next = rx_pkg::seq_check;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state        <= rx_pkg::seq_idle;
            payload_left <= '0;
            pad_left     <= '0;
            fcs_left     <= '0;
        end else begin
            state        <= state_next;
            payload_left <= payload_next;
            pad_left     <= pad_next;
            fcs_left     <= fcs_next;
        end
    end

    // Header completes only while the header is being collected
    assert property (@(posedge clock) disable iff (!reset_n)
        header_done |-> (state == rx_pkg::seq_header));

    assert property (@(posedge clock) disable iff (!reset_n)
        (state == rx_pkg::seq_check) |-> !$isunknown(fcs_match));

endmodule

// File: slot_router.sv
`timescale 1ns/10ps
module slot_router #(
    parameter int receive_slots = 2
) (
    input  logic                        clock,
    input  logic                        reset_n,
    input  rx_pkg::rx_byte_t            rx_byte,
    input  logic [receive_slots-1:0]    receive_slot_enable,
    input  logic                        frame_start,
    input  logic                        payload_byte,
    input  rx_pkg::verdict_t            verdict,
    output logic [7:0]                  payload,
    output logic [receive_slots-1:0]    payload_valid,
    output logic [receive_slots-1:0]    good_frame,
    output logic [receive_slots-1:0]    bad_frame
);

    localparam int select_bits = (receive_slots > 1) ? $clog2(receive_slots) : 1;

    logic [select_bits-1:0]   slot_select;
    logic [select_bits-1:0]   highest_enabled;
    logic [receive_slots-1:0] slot_onehot;

    // Highest enabled slot wins
    always_comb begin
        highest_enabled = '0;
        for (int i = 0; i < receive_slots; i++) begin
            if (receive_slot_enable[i]) begin
                highest_enabled = select_bits'(i);
            end
        end
    end

    assign slot_onehot = receive_slots'(1) << slot_select;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            slot_select   <= '0;
            payload_valid <= '0;
            good_frame    <= '0;
            bad_frame     <= '0;
        end else begin
            if (frame_start) begin
                slot_select <= highest_enabled;
            end
            payload_valid <= payload_byte ? slot_onehot : '0;
            good_frame    <= verdict.good ? slot_onehot : '0;
            bad_frame     <= verdict.bad ? slot_onehot : '0;
        end
    end

    always_ff @(posedge clock) begin
        if (payload_byte) begin
            payload <= rx_byte.data;
        end
    end

    // A frame is never judged good and bad at once
    assert property (@(posedge clock) disable iff (!reset_n)
        !(verdict.good && verdict.bad));

endmodule

// File: udp_frame_receiver.sv
`timescale 1ns/10ps
module udp_frame_receiver #(
    parameter int receive_slots = 2
) (
    input  logic                        clock,
    input  logic                        reset_n,
    input  rx_pkg::rx_byte_t            rx_byte,
    input  logic [receive_slots-1:0]    receive_slot_enable,
    output logic [7:0]                  payload,
    output logic [receive_slots-1:0]    payload_valid,
    output logic [receive_slots-1:0]    good_frame,
    output logic [receive_slots-1:0]    bad_frame,
    output logic [15:0]                 udp_destination_port
);

    frame_pkg::header_word_u header;
    rx_pkg::verdict_t        verdict;
    logic                    header_done;
    logic                    capture;
    logic                    crc_restart;
    logic                    crc_byte;
    logic                    fcs_byte;
    logic                    fcs_match;
    logic                    frame_start;
    logic                    payload_byte;
    logic                    any_slot;

    assign any_slot             = |receive_slot_enable;
    assign udp_destination_port = header.fields.udp_destination_port;

    header_capture u_header_capture (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx_byte     (rx_byte),
        .capture     (capture),
        .restart     (crc_restart),
        .header      (header),
        .header_done (header_done)
    );

    frame_check u_frame_check (
        .clock       (clock),
        .reset_n     (reset_n),
        .rx_byte     (rx_byte),
        .crc_restart (crc_restart),
        .crc_byte    (crc_byte),
        .fcs_byte    (fcs_byte),
        .fcs_match   (fcs_match)
    );

    frame_sequencer u_frame_sequencer (
        .clock        (clock),
        .reset_n      (reset_n),
        .rx_byte      (rx_byte),
        .header       (header),
        .header_done  (header_done),
        .fcs_match    (fcs_match),
        .any_slot     (any_slot),
        .capture      (capture),
        .crc_restart  (crc_restart),
        .crc_byte     (crc_byte),
        .fcs_byte     (fcs_byte),
        .frame_start  (frame_start),
        .payload_byte (payload_byte),
        .verdict      (verdict)
    );

    slot_router #(
        .receive_slots (receive_slots)
    ) u_slot_router (
        .clock               (clock),
        .reset_n             (reset_n),
        .rx_byte             (rx_byte),
        .receive_slot_enable (receive_slot_enable),
        .frame_start         (frame_start),
        .payload_byte        (payload_byte),
        .verdict             (verdict),
        .payload             (payload),
        .payload_valid       (payload_valid),
        .good_frame          (good_frame),
        .bad_frame           (bad_frame)
    );

endmodule

// File: tb_frame_builder.svh
`ifndef TB_FRAME_BUILDER_SVH
`define TB_FRAME_BUILDER_SVH

// Frame under construction and its payload
logic [7:0] frame_q[$];
logic [7:0] payload_q[$];

// Reference CRC-32, one bit at a time, lsb of each byte first
function automatic logic [rx_pkg::crc_residue_bits-1:0] reference_crc();
    logic [rx_pkg::crc_residue_bits-1:0] crc;
    logic                                feedback;
    crc = '1;
    foreach (frame_q[i]) begin
        for (int b = 0; b < 8; b++) begin
            feedback = crc[0] ^ frame_q[i][b];
            crc = crc >> 1;
            if (feedback) begin
                crc = crc ^ 32'hEDB8_8320;
            end
        end
    end
    return ~crc;
endfunction

task automatic build_frame(input logic [15:0] ether_type, input logic [7:0] protocol,
                           input logic [15:0] flags_offset, input logic [15:0] port,
                           input int payload_count);
    frame_pkg::header_word_u             hdr;
    logic [rx_pkg::crc_residue_bits-1:0] fcs;
    hdr = '0;
    hdr.fields.mac_destination          = 48'h02_00_00_00_00_01;
    hdr.fields.mac_source               = 48'h02_00_00_00_00_02;
    hdr.fields.ether_type               = ether_type;
    hdr.fields.ipv4_version_ihl         = 8'h45;
    hdr.fields.ipv4_total_length        = 16'(28 + payload_count);
    hdr.fields.ipv4_flags_offset        = flags_offset;
    hdr.fields.ipv4_time_to_live        = 8'd64;
    hdr.fields.ipv4_protocol            = protocol;
    hdr.fields.ipv4_source_address      = 32'hC0A8_0001;
    hdr.fields.ipv4_destination_address = 32'hC0A8_0002;
    hdr.fields.udp_source_port          = 16'd5000;
    hdr.fields.udp_destination_port     = port;
    hdr.fields.udp_length = 16'(frame_pkg::udp_header_bytes + payload_count);
    frame_q.delete();
    payload_q.delete();
    for (int i = 0; i < frame_pkg::header_bytes; i++) begin
        frame_q.push_back(hdr.bytes[i]);
    end
    for (int i = 0; i < payload_count; i++) begin
        payload_q.push_back(8'($urandom));
        frame_q.push_back(payload_q[i]);
    end
    // Zero pad up to the minimum frame
    while (frame_q.size() < frame_pkg::min_frame_bytes) begin
        frame_q.push_back(8'h00);
    end
    fcs = reference_crc();
    for (int i = 0; i < frame_pkg::fcs_bytes; i++) begin
        frame_q.push_back(fcs[8*i +: 8]);
    end
endtask

task automatic corrupt_fcs();
    frame_q[frame_q.size() - 2] = frame_q[frame_q.size() - 2] ^ 8'h5A;
endtask

`endif

// File: tb_udp_frame_receiver.sv
`timescale 1ns/10ps
module tb_udp_frame_receiver;

    localparam int receive_slots   = 2;
    localparam int verdict_timeout = 300;
    localparam int settle_cycles   = 6;

    logic                     clock;
    logic                     reset_n;
    rx_pkg::rx_byte_t         rx_byte;
    logic [receive_slots-1:0] receive_slot_enable;
    logic [7:0]               payload;
    logic [receive_slots-1:0] payload_valid;
    logic [receive_slots-1:0] good_frame;
    logic [receive_slots-1:0] bad_frame;
    logic [15:0]              udp_destination_port;

    // Observed and expected outputs
    logic [7:0]               seen_data[$];
    logic [receive_slots-1:0] seen_slot[$];
    logic [receive_slots-1:0] seen_good[$];
    logic [receive_slots-1:0] seen_bad[$];
    logic [7:0]               expect_data[$];
    logic [receive_slots-1:0] expect_slot[$];

    `include "tb_frame_builder.svh"

    udp_frame_receiver #(
        .receive_slots (receive_slots)
    ) u_dut (
        .clock                (clock),
        .reset_n              (reset_n),
        .rx_byte              (rx_byte),
        .receive_slot_enable  (receive_slot_enable),
        .payload              (payload),
        .payload_valid        (payload_valid),
        .good_frame           (good_frame),
        .bad_frame            (bad_frame),
        .udp_destination_port (udp_destination_port)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    // Outputs are stable on the falling edge
    always @(negedge clock) begin
        if (reset_n) begin
            if (|payload_valid) begin
                seen_data.push_back(payload);
                seen_slot.push_back(payload_valid);
            end
            if (|good_frame) begin
                seen_good.push_back(good_frame);
            end
            if (|bad_frame) begin
                seen_bad.push_back(bad_frame);
            end
        end
    end

    ////////////////////
    // Reporting and compares

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_with_failure();
    endtask

    task automatic compare_byte(input string name, input logic [7:0] expected,
                                input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_slots(input string name, input logic [receive_slots-1:0] expected,
                                 input logic [receive_slots-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %b, got %b", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic compare_port(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
            stop_with_failure();
        end
    endtask

    ////////////////////
    // Drive and collect

    task automatic set_enable(input logic [receive_slots-1:0] value);
        @(posedge clock);
        receive_slot_enable <= value;
    endtask

    task automatic send_bytes(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clock);
            rx_byte <= '{valid: 1'b1, start: (i == 0), data: frame_q[i]};
        end
    endtask

    task automatic send_frame();
        send_bytes(frame_q.size());
        @(posedge clock);
        rx_byte <= '0;
    endtask

    task automatic expect_payload(input int count, input logic [receive_slots-1:0] slot);
        for (int i = 0; i < count; i++) begin
            expect_data.push_back(payload_q[i]);
            expect_slot.push_back(slot);
        end
    endtask

    task automatic wait_for_verdicts(input int total);
        int cycles;
        cycles = 0;
        while (seen_good.size() + seen_bad.size() < total) begin
            @(posedge clock);
            cycles++;
            if (cycles > verdict_timeout) begin
                report_problem("no good_frame or bad_frame pulse arrived in time");
            end
        end
        // Room for stray or stretched pulses
        cycles = 0;
        while (cycles < settle_cycles) begin
            @(posedge clock);
            cycles++;
        end
    endtask

    task automatic check_results(input logic [receive_slots-1:0] good_slot,
                                 input logic [receive_slots-1:0] bad_slot);
        int good_count;
        int bad_count;
        good_count = (good_slot != '0) ? 1 : 0;
        bad_count  = (bad_slot != '0) ? 1 : 0;
        wait_for_verdicts(good_count + bad_count);
        if (seen_data.size() != expect_data.size()) begin
            report_problem($sformatf("%0d payload bytes arrived where %0d were expected",
                                     seen_data.size(), expect_data.size()));
        end
        while (expect_data.size() > 0) begin
            compare_byte("payload", expect_data.pop_front(), seen_data.pop_front());
            compare_slots("payload_valid", expect_slot.pop_front(), seen_slot.pop_front());
        end
        if (seen_good.size() != good_count || seen_bad.size() != bad_count) begin
            report_problem($sformatf("saw %0d good and %0d bad pulses, expected %0d and %0d",
                                     seen_good.size(), seen_bad.size(), good_count, bad_count));
        end
        if (good_count > 0) begin
            compare_slots("good_frame", good_slot, seen_good.pop_front());
        end
        if (bad_count > 0) begin
            compare_slots("bad_frame", bad_slot, seen_bad.pop_front());
        end
    endtask

    ////////////////////
    // Directed tests

    task automatic test_basic_frame();
        set_enable(2'b10);
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd4791, 30);
        expect_payload(30, 2'b10);
        send_frame();
        check_results(2'b10, 2'b00);
        compare_port("udp_destination_port", 16'd4791, udp_destination_port);
    endtask

    task automatic test_padded_frame();
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd53, 5);
        expect_payload(5, 2'b10);
        send_frame();
        check_results(2'b10, 2'b00);
        compare_port("udp_destination_port", 16'd53, udp_destination_port);
    endtask

    task automatic test_bad_fcs();
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd69, 30);
        corrupt_fcs();
        expect_payload(30, 2'b10);
        send_frame();
        check_results(2'b00, 2'b10);
    endtask

    task automatic test_filtered_frames();
        build_frame(16'h0806, frame_pkg::ip_protocol_udp, 16'h0000, 16'd100, 20);
        send_frame();
        check_results(2'b00, 2'b00);
        build_frame(frame_pkg::ethertype_ipv4, 8'd6, 16'h0000, 16'd101, 20);
        send_frame();
        check_results(2'b00, 2'b00);
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0001, 16'd102, 20);
        send_frame();
        check_results(2'b00, 2'b00);
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd103, 20);
        expect_payload(20, 2'b10);
        send_frame();
        check_results(2'b10, 2'b00);
    endtask

    task automatic test_mid_frame_start();
        set_enable(2'b11);
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd1000, 30);
        send_bytes(frame_pkg::header_bytes + 10);
        expect_payload(10, 2'b10);
        // New frame lands on slot 0 while the old one was on slot 1
        receive_slot_enable <= 2'b01;
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd2000, 20);
        expect_payload(20, 2'b01);
        send_frame();
        check_results(2'b01, 2'b10);
        compare_port("udp_destination_port", 16'd2000, udp_destination_port);
    endtask

    task automatic test_slot_selection();
        set_enable(2'b11);
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd3000, 12);
        expect_payload(12, 2'b10);
        send_frame();
        check_results(2'b10, 2'b00);
        set_enable(2'b00);
        build_frame(frame_pkg::ethertype_ipv4, frame_pkg::ip_protocol_udp, 16'h0000, 16'd3001, 12);
        send_frame();
        check_results(2'b00, 2'b00);
    endtask

    initial begin
        void'($urandom(42));
        reset_n             = 1'b0;
        rx_byte             = '0;
        receive_slot_enable = '0;
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        compare_slots("payload_valid", '0, payload_valid);
        compare_slots("good_frame", '0, good_frame);
        compare_slots("bad_frame", '0, bad_frame);
        compare_port("udp_destination_port", 16'h0000, udp_destination_port);
        test_basic_frame();
        test_padded_frame();
        test_bad_fcs();
        test_filtered_frames();
        test_mid_frame_start();
        test_slot_selection();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: udp_frame_receiver.f
+incdir+.
frame_pkg.sv
rx_pkg.sv
header_capture.sv
frame_check.sv
frame_sequencer.sv
slot_router.sv
udp_frame_receiver.sv
tb_udp_frame_receiver.sv

// File: Bender.yml
package:
  name: udp_frame_receiver

sources:
  - frame_pkg.sv
  - rx_pkg.sv
  - header_capture.sv
  - frame_check.sv
  - frame_sequencer.sv
  - slot_router.sv
  - udp_frame_receiver.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_udp_frame_receiver.sv
